// ==== source/mac_lanes.sv ====
`timescale 1ns/1ns

module mac_lanes #(
  parameter int LANES      = tpu_geom_pkg::LANES,
  parameter int DATA_WIDTH = tpu_geom_pkg::DATA_WIDTH,
  parameter int ACC_WIDTH  = tpu_geom_pkg::ACC_WIDTH
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [LANES*DATA_WIDTH-1:0] a_word,
  input  logic [LANES*DATA_WIDTH-1:0] b_word,
  input  logic                        step_valid,
  input  logic                        step_first,
  input  logic                        step_last,
  output logic [LANES*ACC_WIDTH-1:0]  acc_word,
  output logic                        acc_valid
);

  logic signed [2*DATA_WIDTH-1:0] prod [LANES];
  logic signed [ACC_WIDTH-1:0]    acc  [LANES];

  // lane j of A times lane j of B
  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      prod[j] = $signed(a_word[j*DATA_WIDTH +: DATA_WIDTH])
              * $signed(b_word[j*DATA_WIDTH +: DATA_WIDTH]);
    end
  end

  // first step restarts the sum, so no clear between runs
  always_ff @(posedge clk) begin
    if (step_valid) begin
      for (int j = 0; j < LANES; j++) begin
        if (step_first) begin
          acc[j] <= ACC_WIDTH'(prod[j]);
        end else begin
          acc[j] <= acc[j] + ACC_WIDTH'(prod[j]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= step_valid && step_last;
    end
  end

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      acc_word[j*ACC_WIDTH +: ACC_WIDTH] = acc[j];
    end
  end

endmodule

// ==== source/norm_act.sv ====
`timescale 1ns/1ns

module norm_act #(
  parameter int LANES      = tpu_geom_pkg::LANES,
  parameter int DATA_WIDTH = tpu_geom_pkg::DATA_WIDTH,
  parameter int ACC_WIDTH  = tpu_geom_pkg::ACC_WIDTH
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [LANES*ACC_WIDTH-1:0]  acc_word,
  input  logic                        acc_valid,
  input  logic                        norm_en,
  input  logic                        relu_en,
  input  logic [ACC_WIDTH-1:0]        mean,
  input  logic [DATA_WIDTH-1:0]       inv_var,
  output logic [LANES*DATA_WIDTH-1:0] out_word,
  output logic                        out_valid
);

  import tpu_geom_pkg::*;

  // holds (acc - mean) * inv_var without overflow
  localparam int NW = ACC_WIDTH + DATA_WIDTH + 1;
  localparam logic signed [NW-1:0] SAT_HI = NW'(2**(DATA_WIDTH-1) - 1);
  localparam logic signed [NW-1:0] SAT_LO = -(SAT_HI + 1);

  logic signed [NW-1:0]         scaled [LANES];
  logic signed [NW-1:0]         normed [LANES];
  logic        [DATA_WIDTH-1:0] sat    [LANES];

  always_comb begin
    for (int j = 0; j < LANES; j++) begin
      scaled[j] = ((NW'($signed(acc_word[j*ACC_WIDTH +: ACC_WIDTH])) - NW'($signed(mean)))
                * NW'($signed(inv_var))) >>> NORM_SHIFT;
      normed[j] = norm_en ? scaled[j] : NW'($signed(acc_word[j*ACC_WIDTH +: ACC_WIDTH]));
      if (relu_en && normed[j] < 0) begin
        normed[j] = '0;
      end
      // clamp to the signed element range
      if (normed[j] > SAT_HI) begin
        sat[j] = SAT_HI[DATA_WIDTH-1:0];
      end else if (normed[j] < SAT_LO) begin
        sat[j] = SAT_LO[DATA_WIDTH-1:0];
      end else begin
        sat[j] = normed[j][DATA_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      for (int j = 0; j < LANES; j++) begin
        out_word[j*DATA_WIDTH +: DATA_WIDTH] <= sat[j];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= acc_valid;
    end
  end

endmodule

// ==== source/tile_ram.sv ====
`timescale 1ns/1ns

module tile_ram #(
  parameter int LANES      = tpu_geom_pkg::LANES,
  parameter int DATA_WIDTH = tpu_geom_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH = tpu_geom_pkg::ADDR_WIDTH
) (
  input  logic                        clk,
  input  logic [ADDR_WIDTH-1:0]       rd_addr,
  input  logic [ADDR_WIDTH-1:0]       wr_addr,
  input  logic                        wr_en,
  input  logic [LANES*DATA_WIDTH-1:0] wr_data,
  output logic [LANES*DATA_WIDTH-1:0] rd_data,
  input  logic [ADDR_WIDTH-1:0]       ext_addr,
  input  logic [LANES-1:0]            ext_we,
  input  logic [LANES*DATA_WIDTH-1:0] ext_wdata,
  output logic [LANES*DATA_WIDTH-1:0] ext_rdata
);

  logic [LANES*DATA_WIDTH-1:0] mem [0:2**ADDR_WIDTH-1];

  // both ports read registered, one cycle after the address
  always_ff @(posedge clk) begin
    // internal side writes the whole result word
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    // external side has one enable per lane
    for (int i = 0; i < LANES; i++) begin
      if (ext_we[i]) begin
        mem[ext_addr][i*DATA_WIDTH +: DATA_WIDTH] <= ext_wdata[i*DATA_WIDTH +: DATA_WIDTH];
      end
    end
    rd_data   <= mem[rd_addr];
    ext_rdata <= mem[ext_addr];
  end

endmodule

// ==== source/tile_regs.sv ====
`timescale 1ns/1ns

module tile_regs #(
  parameter int DATA_WIDTH = 8,
  parameter int ADDR_WIDTH = 6,
  parameter int K_WIDTH    = 4,
  parameter int ACC_WIDTH  = 20
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           cfg_we,
  input  logic [2:0]                     cfg_addr,
  input  logic [tpu_ctrl_pkg::CFG_WIDTH-1:0] cfg_wdata,
  output logic [tpu_ctrl_pkg::CFG_WIDTH-1:0] cfg_rdata,
  input  logic                           busy,
  input  logic                           done,
  output logic                           start,
  output logic                           norm_en,
  output logic                           relu_en,
  output logic [ADDR_WIDTH-1:0]          addr_a,
  output logic [ADDR_WIDTH-1:0]          addr_b,
  output logic [ADDR_WIDTH-1:0]          addr_c,
  output logic [K_WIDTH-1:0]             k_dim,
  output logic [ACC_WIDTH-1:0]           mean,
  output logic [DATA_WIDTH-1:0]          inv_var
);

  import tpu_ctrl_pkg::*;

  reg_addr_e             addr_sel;
  logic                  done_flag;
  logic [CFG_WIDTH-1:0]  ctrl_view;

  assign addr_sel = reg_addr_e'(cfg_addr);

  //////////////////////////////
  // configuration writes
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      start     <= 1'b0;
      norm_en   <= 1'b0;
      relu_en   <= 1'b0;
      addr_a    <= '0;
      addr_b    <= '0;
      addr_c    <= '0;
      k_dim     <= '0;
      mean      <= '0;
      inv_var   <= '0;
      done_flag <= 1'b0;
    end else begin
      // a start request while running is dropped
      start <= cfg_we && addr_sel == REG_CTRL && cfg_wdata[CTRL_START_BIT] && !busy && !start;
      if (cfg_we) begin
        case (addr_sel)
          REG_CTRL: begin
            norm_en <= cfg_wdata[CTRL_NORM_BIT];
            relu_en <= cfg_wdata[CTRL_RELU_BIT];
          end
          REG_ADDR_A:  addr_a  <= cfg_wdata[ADDR_WIDTH-1:0];
          REG_ADDR_B:  addr_b  <= cfg_wdata[ADDR_WIDTH-1:0];
          REG_ADDR_C:  addr_c  <= cfg_wdata[ADDR_WIDTH-1:0];
          REG_K_DIM:   k_dim   <= cfg_wdata[K_WIDTH-1:0];
          // mean is sign extended up to accumulator width
          REG_MEAN:    mean    <= ACC_WIDTH'(signed'(cfg_wdata));
          REG_INV_VAR: inv_var <= cfg_wdata[DATA_WIDTH-1:0];
          default: ;
        endcase
      end
      // sticky done, cleared by the next start
      if (start) begin
        done_flag <= 1'b0;
      end else if (done) begin
        done_flag <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////

  always_comb begin
    ctrl_view                = '0;
    ctrl_view[CTRL_NORM_BIT] = norm_en;
    ctrl_view[CTRL_RELU_BIT] = relu_en;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_rdata <= '0;
    end else begin
      case (addr_sel)
        REG_CTRL:    cfg_rdata <= ctrl_view;
        REG_ADDR_A:  cfg_rdata <= CFG_WIDTH'(addr_a);
        REG_ADDR_B:  cfg_rdata <= CFG_WIDTH'(addr_b);
        REG_ADDR_C:  cfg_rdata <= CFG_WIDTH'(addr_c);
        REG_K_DIM:   cfg_rdata <= CFG_WIDTH'(k_dim);
        REG_MEAN:    cfg_rdata <= CFG_WIDTH'(signed'(mean));
        REG_INV_VAR: cfg_rdata <= CFG_WIDTH'(inv_var);
        // bit 0 busy, bit 1 sticky done
        default:     cfg_rdata <= CFG_WIDTH'({done_flag, busy});
      endcase
    end
  end

endmodule

// ==== source/tile_sequencer.sv ====
`timescale 1ns/1ns

module tile_sequencer #(
  parameter int ADDR_WIDTH = tpu_geom_pkg::ADDR_WIDTH,
  parameter int K_WIDTH    = tpu_geom_pkg::K_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [ADDR_WIDTH-1:0] addr_a,
  input  logic [ADDR_WIDTH-1:0] addr_b,
  input  logic [K_WIDTH-1:0]    k_dim,
  input  logic                  out_valid,
  output logic [ADDR_WIDTH-1:0] rd_addr_a,
  output logic [ADDR_WIDTH-1:0] rd_addr_b,
  output logic                  step_valid,
  output logic                  step_first,
  output logic                  step_last,
  output logic                  busy,
  output logic                  done
);

  import tpu_ctrl_pkg::*;

  seq_state_e             state;
  logic [K_WIDTH-1:0]     step_cnt;
  logic [K_WIDTH-1:0]     k_last;
  logic [ADDR_WIDTH-1:0]  base_a;
  logic [ADDR_WIDTH-1:0]  base_b;
  logic                   fetching;

  assign fetching  = state == ST_FETCH;
  assign busy      = state != ST_IDLE;
  // one operand word per fetch cycle
  assign rd_addr_a = base_a + ADDR_WIDTH'(step_cnt);
  assign rd_addr_b = base_b + ADDR_WIDTH'(step_cnt);

  // operand bases and step count only change when a run is accepted
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      base_a <= addr_a;
      base_b <= addr_b;
      // k of zero runs a single step
      k_last <= (k_dim == '0) ? '0 : k_dim - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_IDLE;
      step_cnt   <= '0;
      step_valid <= 1'b0;
      step_first <= 1'b0;
      step_last  <= 1'b0;
      done       <= 1'b0;
    end else begin
      // flags trail the addresses by the memory read latency
      step_valid <= fetching;
      step_first <= fetching && step_cnt == '0;
      step_last  <= fetching && step_cnt == k_last;
      done       <= 1'b0;
      case (state)
        ST_IDLE: begin
          step_cnt <= '0;
          if (start) begin
            state <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == k_last) begin
            state <= ST_DRAIN;
          end
        end
        // last read word is still on its way to the MAC
        ST_DRAIN: state <= ST_WRITE;
        ST_WRITE: begin
          if (out_valid) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== source/tpu_ctrl_pkg.sv ====
package tpu_ctrl_pkg;

  //////////////////////////////
  // register map
  //////////////////////////////

  typedef enum logic [2:0] {
    REG_CTRL    = 3'd0,
    REG_ADDR_A  = 3'd1,
    REG_ADDR_B  = 3'd2,
    REG_ADDR_C  = 3'd3,
    REG_K_DIM   = 3'd4,
    REG_MEAN    = 3'd5,
    REG_INV_VAR = 3'd6,
    REG_STATUS  = 3'd7
  } reg_addr_e;

  // fields of REG_CTRL, start is self clearing
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_NORM_BIT  = 1;
  localparam int CTRL_RELU_BIT  = 2;

  // register data bus
  localparam int CFG_WIDTH = 16;

  //////////////////////////////
  // sequencer
  //////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DRAIN,
    ST_WRITE
  } seq_state_e;

endpackage

// ==== source/tpu_geom_pkg.sv ====
package tpu_geom_pkg;

  //////////////////////////////
  // lane word layout
  //////////////////////////////

  // lanes packed into one memory word
  localparam int LANES = 4;

  // signed element width of a single lane
  localparam int DATA_WIDTH = 8;

  // word address into the A and B memories
  localparam int ADDR_WIDTH = 6;

  //////////////////////////////
  // compute path
  //////////////////////////////

  // k dimension field, number of fetch steps
  localparam int K_WIDTH = 4;

  // lane accumulator, wide enough for 15 full-scale products
  localparam int ACC_WIDTH = 20;

  // arithmetic shift applied after the inverse variance multiply
  localparam int NORM_SHIFT = 4;

endpackage

// ==== source/tpu_top.sv ====
`timescale 1ns/1ns

module tpu_top #(
  parameter int LANES      = tpu_geom_pkg::LANES,
  parameter int DATA_WIDTH = tpu_geom_pkg::DATA_WIDTH,
  parameter int ADDR_WIDTH = tpu_geom_pkg::ADDR_WIDTH,
  parameter int K_WIDTH    = tpu_geom_pkg::K_WIDTH,
  parameter int ACC_WIDTH  = tpu_geom_pkg::ACC_WIDTH
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               cfg_we,
  input  logic [2:0]                         cfg_addr,
  input  logic [tpu_ctrl_pkg::CFG_WIDTH-1:0] cfg_wdata,
  output logic [tpu_ctrl_pkg::CFG_WIDTH-1:0] cfg_rdata,
  input  logic [ADDR_WIDTH-1:0]              ext_addr_a,
  input  logic [LANES-1:0]                   ext_we_a,
  input  logic [LANES*DATA_WIDTH-1:0]        ext_wdata_a,
  output logic [LANES*DATA_WIDTH-1:0]        ext_rdata_a,
  input  logic [ADDR_WIDTH-1:0]              ext_addr_b,
  input  logic [LANES-1:0]                   ext_we_b,
  input  logic [LANES*DATA_WIDTH-1:0]        ext_wdata_b,
  output logic [LANES*DATA_WIDTH-1:0]        ext_rdata_b,
  output logic                               busy,
  output logic                               done
);

  logic                        start, norm_en, relu_en;
  logic [ADDR_WIDTH-1:0]       addr_a, addr_b, addr_c;
  logic [ADDR_WIDTH-1:0]       rd_addr_a, rd_addr_b;
  logic [K_WIDTH-1:0]          k_dim;
  logic [ACC_WIDTH-1:0]        mean;
  logic [DATA_WIDTH-1:0]       inv_var;
  logic                        step_valid, step_first, step_last;
  logic [LANES*DATA_WIDTH-1:0] a_word, b_word, out_word;
  logic [LANES*ACC_WIDTH-1:0]  acc_word;
  logic                        acc_valid, out_valid;

  //////////////////////////////
  // control
  //////////////////////////////

  tile_regs #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH), .K_WIDTH(K_WIDTH),
              .ACC_WIDTH(ACC_WIDTH)) u_regs (
    .clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata), .busy(busy), .done(done),
    .start(start), .norm_en(norm_en), .relu_en(relu_en), .addr_a(addr_a),
    .addr_b(addr_b), .addr_c(addr_c), .k_dim(k_dim), .mean(mean), .inv_var(inv_var)
  );

  tile_sequencer #(.ADDR_WIDTH(ADDR_WIDTH), .K_WIDTH(K_WIDTH)) u_seq (
    .clk(clk), .reset(reset), .start(start), .addr_a(addr_a), .addr_b(addr_b),
    .k_dim(k_dim), .out_valid(out_valid), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .step_valid(step_valid), .step_first(step_first), .step_last(step_last),
    .busy(busy), .done(done)
  );

  //////////////////////////////
  // operand memories
  //////////////////////////////

  // activations, the result word is written back here at addr_c
  tile_ram #(.LANES(LANES), .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) mem_a (
    .clk(clk), .rd_addr(rd_addr_a), .wr_addr(addr_c), .wr_en(out_valid),
    .wr_data(out_word), .rd_data(a_word), .ext_addr(ext_addr_a), .ext_we(ext_we_a),
    .ext_wdata(ext_wdata_a), .ext_rdata(ext_rdata_a)
  );

  // weights are only read by the tile
  tile_ram #(.LANES(LANES), .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) mem_b (
    .clk(clk), .rd_addr(rd_addr_b), .wr_addr('0), .wr_en(1'b0),
    .wr_data('0), .rd_data(b_word), .ext_addr(ext_addr_b), .ext_we(ext_we_b),
    .ext_wdata(ext_wdata_b), .ext_rdata(ext_rdata_b)
  );

  //////////////////////////////
  // compute path
  //////////////////////////////

  mac_lanes #(.LANES(LANES), .DATA_WIDTH(DATA_WIDTH), .ACC_WIDTH(ACC_WIDTH)) u_mac (
    .clk(clk), .reset(reset), .a_word(a_word), .b_word(b_word),
    .step_valid(step_valid), .step_first(step_first), .step_last(step_last),
    .acc_word(acc_word), .acc_valid(acc_valid)
  );

  norm_act #(.LANES(LANES), .DATA_WIDTH(DATA_WIDTH), .ACC_WIDTH(ACC_WIDTH)) u_norm (
    .clk(clk), .reset(reset), .acc_word(acc_word), .acc_valid(acc_valid),
    .norm_en(norm_en), .relu_en(relu_en), .mean(mean), .inv_var(inv_var),
    .out_word(out_word), .out_valid(out_valid)
  );

endmodule

// ==== tpu_top.f ====
+incdir+verif
source/tpu_geom_pkg.sv
source/tpu_ctrl_pkg.sv
source/tile_ram.sv
source/tile_regs.sv
source/tile_sequencer.sv
source/mac_lanes.sv
source/norm_act.sv
source/tpu_top.sv
verif/tpu_tb.sv

// ==== verif/tpu_tb_ref.svh ====
// expected result word of one operation, taken from the memory copies
//   acc = sum over t < k of lane j of A times lane j of B
//   optional ((acc - mean) * inv_var) >>> NORM_SHIFT, optional relu, then saturate

function automatic int lane_of(input logic [WW-1:0] word, input int j);
  logic signed [DATA_WIDTH-1:0] e;
  e = word[j*DATA_WIDTH +: DATA_WIDTH];
  return int'(e);
endfunction

function automatic logic [WW-1:0] ref_word(input int base_a, input int base_b, input int k,
                                           input int mean, input int inv_var,
                                           input bit norm, input bit relu);
  logic [WW-1:0] word;
  longint acc;
  longint v;
  longint hi;
  int steps;
  word  = '0;
  hi    = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
  // a k of zero still fetches one word
  steps = (k == 0) ? 1 : k;
  for (int j = 0; j < LANES; j++) begin
    acc = 0;
    for (int t = 0; t < steps; t++) begin
      acc += longint'(lane_of(model_a[(base_a + t) % DEPTH], j))
           * longint'(lane_of(model_b[(base_b + t) % DEPTH], j));
    end
    v = norm ? (((acc - mean) * inv_var) >>> NORM_SHIFT) : acc;
    if (relu && v < 0) begin
      v = 0;
    end
    if (v > hi) begin
      v = hi;
    end else if (v < -hi - 1) begin
      v = -hi - 1;
    end
    word[j*DATA_WIDTH +: DATA_WIDTH] = v[DATA_WIDTH-1:0];
  end
  return word;
endfunction

// ==== verif/tpu_tb.sv ====
`timescale 1ns/1ns

module tpu_tb;

  import tpu_geom_pkg::*;
  import tpu_ctrl_pkg::*;

  localparam int WW         = LANES * DATA_WIDTH;
  localparam int DEPTH      = 2 ** ADDR_WIDTH;
  localparam int WAIT_LIMIT = 100;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  cfg_we;
  logic [2:0]            cfg_addr;
  logic [CFG_WIDTH-1:0]  cfg_wdata;
  logic [CFG_WIDTH-1:0]  cfg_rdata;
  logic [ADDR_WIDTH-1:0] ext_addr_a;
  logic [ADDR_WIDTH-1:0] ext_addr_b;
  logic [LANES-1:0]      ext_we_a;
  logic [LANES-1:0]      ext_we_b;
  logic [WW-1:0]         ext_wdata_a;
  logic [WW-1:0]         ext_wdata_b;
  logic [WW-1:0]         ext_rdata_a;
  logic [WW-1:0]         ext_rdata_b;
  logic                  busy;
  logic                  done;

  // copies of both memories as the testbench wrote them
  logic [WW-1:0] model_a [DEPTH];
  logic [WW-1:0] model_b [DEPTH];

  integer seed = 45;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  // operation in flight
  int cur_a, cur_b, cur_c, cur_k, cur_mean, cur_iv;
  bit cur_norm, cur_relu;

  // handoff to the compare process
  logic          cmp_pending = 1'b0;
  logic [WW-1:0] cmp_exp;
  logic [WW-1:0] cmp_got;

  `include "tpu_tb_ref.svh"

  tpu_top #(
    .LANES(LANES), .DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
    .K_WIDTH(K_WIDTH), .ACC_WIDTH(ACC_WIDTH)
  ) uut (
    .clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
    .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
    .ext_addr_a(ext_addr_a), .ext_we_a(ext_we_a), .ext_wdata_a(ext_wdata_a),
    .ext_rdata_a(ext_rdata_a), .ext_addr_b(ext_addr_b), .ext_we_b(ext_we_b),
    .ext_wdata_b(ext_wdata_b), .ext_rdata_b(ext_rdata_b), .busy(busy), .done(done)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [CFG_WIDTH-1:0] ctrl_word(input bit start, input bit norm,
                                                    input bit relu);
    logic [CFG_WIDTH-1:0] w;
    w                 = '0;
    w[CTRL_START_BIT] = start;
    w[CTRL_NORM_BIT]  = norm;
    w[CTRL_RELU_BIT]  = relu;
    return w;
  endfunction

  // value a register shows after a write, limited to its field width
  function automatic logic [CFG_WIDTH-1:0] readback_of(input reg_addr_e r,
                                                      input logic [CFG_WIDTH-1:0] d);
    logic [CFG_WIDTH-1:0] m;
    case (r)
      REG_CTRL:    m = ctrl_word(1'b0, 1'b1, 1'b1);
      REG_ADDR_A,
      REG_ADDR_B,
      REG_ADDR_C:  m = CFG_WIDTH'((1 << ADDR_WIDTH) - 1);
      REG_K_DIM:   m = CFG_WIDTH'((1 << K_WIDTH) - 1);
      REG_INV_VAR: m = CFG_WIDTH'((1 << DATA_WIDTH) - 1);
      default:     m = '1;
    endcase
    return d & m;
  endfunction

  task automatic mismatch(input string name, input logic [63:0] expv, input logic [63:0] gotv);
    $display("ERR time %0t %s expected %0h got %0h", $time, name, expv, gotv);
    errors++;
  endtask

  task automatic finish_run();
    $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %0d %s FAILED with %0d mismatches", tests_run, name, errors - err_before);
    end else begin
      $display("test %0d %s ok", tests_run, name);
    end
  endtask

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  // all tasks start and end on a falling edge
  task automatic cfg_write(input reg_addr_e addr, input logic [CFG_WIDTH-1:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic cfg_read(input reg_addr_e addr, output logic [CFG_WIDTH-1:0] data);
    cfg_addr = addr;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  // only the lanes set in lanes are written
  task automatic lane_write(input bit to_b, input int addr, input logic [LANES-1:0] lanes,
                            input logic [WW-1:0] word);
    for (int i = 0; i < LANES; i++) begin
      if (lanes[i] && to_b) begin
        model_b[addr % DEPTH][i*DATA_WIDTH +: DATA_WIDTH] = word[i*DATA_WIDTH +: DATA_WIDTH];
      end else if (lanes[i]) begin
        model_a[addr % DEPTH][i*DATA_WIDTH +: DATA_WIDTH] = word[i*DATA_WIDTH +: DATA_WIDTH];
      end
    end
    if (to_b) begin
      ext_addr_b  = ADDR_WIDTH'(addr);
      ext_we_b    = lanes;
      ext_wdata_b = word;
    end else begin
      ext_addr_a  = ADDR_WIDTH'(addr);
      ext_we_a    = lanes;
      ext_wdata_a = word;
    end
    @(negedge clk);
    ext_we_a = '0;
    ext_we_b = '0;
  endtask

  task automatic mem_write(input bit to_b, input int addr, input logic [WW-1:0] word);
    lane_write(to_b, addr, '1, word);
  endtask

  task automatic mem_read(input bit from_b, input int addr, output logic [WW-1:0] word);
    if (from_b) begin
      ext_addr_b = ADDR_WIDTH'(addr);
    end else begin
      ext_addr_a = ADDR_WIDTH'(addr);
    end
    @(negedge clk);
    word = from_b ? ext_rdata_b : ext_rdata_a;
  endtask

  //////////////////////////////
  // operations
  //////////////////////////////

  task automatic launch_op(input int a, input int b, input int c, input int k, input int mean,
                           input int iv, input bit norm, input bit relu);
    cur_a    = a;
    cur_b    = b;
    cur_c    = c;
    cur_k    = k;
    cur_mean = mean;
    cur_iv   = iv;
    cur_norm = norm;
    cur_relu = relu;
    cfg_write(REG_ADDR_A, CFG_WIDTH'(a));
    cfg_write(REG_ADDR_B, CFG_WIDTH'(b));
    cfg_write(REG_ADDR_C, CFG_WIDTH'(c));
    cfg_write(REG_K_DIM, CFG_WIDTH'(k));
    cfg_write(REG_MEAN, CFG_WIDTH'(mean));
    cfg_write(REG_INV_VAR, CFG_WIDTH'(iv));
    cfg_write(REG_CTRL, ctrl_word(1'b1, norm, relu));
  endtask

  task automatic wait_for_done();
    int n;
    n = 0;
    while (!done && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      $display("timeout, done never pulsed after start");
      errors++;
      finish_run();
    end
  endtask

  // reads the stored word and hands it to the compare process
  task automatic check_result();
    logic [WW-1:0] got;
    int n;
    mem_read(1'b0, cur_c, got);
    cmp_exp     = ref_word(cur_a, cur_b, cur_k, cur_mean, cur_iv, cur_norm, cur_relu);
    cmp_got     = got;
    cmp_pending = 1'b1;
    n = 0;
    while (cmp_pending && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (cmp_pending) begin
      $display("timeout, the compare process never took the result");
      errors++;
      finish_run();
    end
    model_a[cur_c % DEPTH] = cmp_exp;
  endtask

  task automatic run_op(input int a, input int b, input int c, input int k, input int mean,
                        input int iv, input bit norm, input bit relu);
    launch_op(a, b, c, k, mean, iv, norm, relu);
    wait_for_done();
    check_result();
  endtask

  // compare process, sampled on the rising edge between two drives
  always @(posedge clk) begin
    if (cmp_pending) begin
      if (cmp_got !== cmp_exp) begin
        mismatch("ext_rdata_a", cmp_exp, cmp_got);
      end
      cmp_pending = 1'b0;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [CFG_WIDTH-1:0] rd;
    logic [CFG_WIDTH-1:0] wd;
    logic [WW-1:0]        w;
    logic [WW-1:0]        wa;
    logic [WW-1:0]        wb;
    int e0;
    int n;
    int done_pulses;

    reset       = 1'b1;
    cfg_we      = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    ext_addr_a  = '0;
    ext_addr_b  = '0;
    ext_we_a    = '0;
    ext_we_b    = '0;
    ext_wdata_a = '0;
    ext_wdata_b = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // reset state, memory and register readback
    e0 = errors;
    if (busy !== 1'b0) begin
      mismatch("busy", 0, busy);
    end
    if (done !== 1'b0) begin
      mismatch("done", 0, done);
    end
    for (int i = 0; i < DEPTH; i++) begin
      mem_write(1'b0, i, $random(seed));
      mem_write(1'b1, i, $random(seed));
    end
    for (int i = 0; i < DEPTH; i++) begin
      mem_read(1'b0, i, w);
      if (w !== model_a[i]) begin
        mismatch("ext_rdata_a", model_a[i], w);
      end
      mem_read(1'b1, i, w);
      if (w !== model_b[i]) begin
        mismatch("ext_rdata_b", model_b[i], w);
      end
    end
    // a partial write keeps the disabled lanes
    for (int i = 0; i < 4; i++) begin
      lane_write(1'b0, i, LANES'($random(seed)), $random(seed));
      lane_write(1'b1, i, LANES'($random(seed)), $random(seed));
      mem_read(1'b0, i, w);
      if (w !== model_a[i]) begin
        mismatch("ext_rdata_a", model_a[i], w);
      end
      mem_read(1'b1, i, w);
      if (w !== model_b[i]) begin
        mismatch("ext_rdata_b", model_b[i], w);
      end
    end
    for (int r = 0; r < 7; r++) begin
      wd = CFG_WIDTH'($random(seed));
      if (r == REG_CTRL) begin
        wd[CTRL_START_BIT] = 1'b0;
      end
      cfg_write(reg_addr_e'(r), wd);
      cfg_read(reg_addr_e'(r), rd);
      if (rd !== readback_of(reg_addr_e'(r), wd)) begin
        mismatch("cfg_rdata", readback_of(reg_addr_e'(r), wd), rd);
      end
    end
    cfg_read(REG_STATUS, rd);
    if (rd !== '0) begin
      mismatch("cfg_rdata", 0, rd);
    end
    end_test("reset and readback", e0);

    // plain multiply accumulate, results go to the top of memory A
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      run_op(rand_below(16), rand_below(48), 48 + i, 1 + rand_below(8), 0, 0, 1'b0, 1'b0);
    end
    run_op(3, 9, 54, 0, 0, 0, 1'b0, 1'b0);
    // small operands keep the sums inside the element range
    for (int t = 0; t < 8; t++) begin
      for (int j = 0; j < LANES; j++) begin
        wa[j*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(rand_below(7) - 3);
        wb[j*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(rand_below(7) - 3);
      end
      mem_write(1'b0, 24 + t, wa);
      mem_write(1'b1, 24 + t, wb);
    end
    run_op(24, 24, 55, 8, 0, 0, 1'b0, 1'b0);
    end_test("plain mac", e0);

    e0 = errors;
    for (int i = 0; i < 6; i++) begin
      run_op(rand_below(16), rand_below(48), 56 + i, 1 + rand_below(8),
             $random(seed) % 4096, $random(seed) % 32, 1'b1, 1'b0);
    end
    run_op(24, 24, 62, 8, $random(seed) % 64, $random(seed) % 32, 1'b1, 1'b0);
    end_test("normalization", e0);

    // lanes 0 and 1 get negative sums, lanes 2 and 3 are random
    e0 = errors;
    for (int t = 0; t < 4; t++) begin
      for (int j = 0; j < LANES; j++) begin
        if (j < 2) begin
          wa[j*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(1 + rand_below(127));
          wb[j*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(-1 - rand_below(127));
        end else begin
          wa[j*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'($random(seed));
          wb[j*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'($random(seed));
        end
      end
      mem_write(1'b0, 32 + t, wa);
      mem_write(1'b1, 32 + t, wb);
    end
    run_op(32, 32, 40, 4, 0, 0, 1'b0, 1'b1);
    run_op(32, 32, 41, 4, $random(seed) % 256, 1 + rand_below(8), 1'b1, 1'b1);
    end_test("relu", e0);

    // second start while busy
    e0 = errors;
    launch_op(5, 11, 63, 8, 0, 0, 1'b0, 1'b0);
    n = 0;
    while (!busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!busy) begin
      $display("timeout, busy never rose after start");
      errors++;
      finish_run();
    end
    cfg_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    n = 0;
    while (busy && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("timeout, busy never fell");
      errors++;
      finish_run();
    end
    done_pulses = 0;
    for (int i = 0; i < 12; i++) begin
      if (done) begin
        done_pulses++;
      end
      @(negedge clk);
    end
    if (done_pulses != 1) begin
      mismatch("done pulse count", 1, done_pulses);
    end
    cfg_read(REG_STATUS, rd);
    if (rd !== CFG_WIDTH'(2)) begin
      mismatch("cfg_rdata", 2, rd);
    end
    check_result();
    end_test("busy and sticky done", e0);

    finish_run();
  end

endmodule
